//--- ppu_settings.svh
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// scanline and frame geometry
`define DOTS_PER_LINE   341
`define LINES_PER_FRAME 262
`define SCREEN_WIDTH    256
`define SCREEN_HEIGHT   240

// vertical blank window
`define VBLANK_LINE     241
`define PRERENDER_LINE  261

// sprite path sizing
`define SPRITE_SLOTS    8
`define LEFT_CLIP_DOTS  8

// attribute byte fields
`define ATTR_PRIO_BIT   5
`define ATTR_HFLIP_BIT  6
`define ATTR_PAL_MSB    1
`define ATTR_PAL_LSB    0

`endif

//--- sprite_pkg.sv
`default_nettype none

package sprite_pkg;

    // column or row counter, wide enough for 341 dots
    typedef logic [8:0] dot_t;

    // one row of a tile, one bit per dot
    typedef logic [7:0] pattern_t;

    // sprite attribute byte
    // bit 7 vflip, 6 hflip, 5 behind background, 1:0 palette
    typedef logic [7:0] attr_t;

    // palette number over the 2-bit pattern value
    typedef logic [3:0] color_index_t;

    // MSB selects the sprite half of the palette
    typedef logic [4:0] pal_addr_t;

    // number of entries held by the loader, 0 to 8
    typedef logic [3:0] slot_count_t;

endpackage

`default_nettype wire

//--- dot_timing.sv
`timescale 1ns/100ps
`default_nettype none
`include "ppu_settings.svh"

module dot_timing (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        nmi_enable,
    output sprite_pkg::dot_t col,
    output sprite_pkg::dot_t row,
    output logic             visible,
    output logic             commit,
    output logic             frame_clear,
    output logic             vblank,
    output logic             nmi_n
);

    logic end_of_line;
    logic end_of_frame;

    assign end_of_line  = (col == sprite_pkg::dot_t'(`DOTS_PER_LINE - 1));
    assign end_of_frame = (row == sprite_pkg::dot_t'(`LINES_PER_FRAME - 1));

    // dot and scanline counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else begin
            if (end_of_line) begin
                col <= '0;
                row <= end_of_frame ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    assign visible = (row < sprite_pkg::dot_t'(`SCREEN_HEIGHT)) &&
                     (col < sprite_pkg::dot_t'(`SCREEN_WIDTH));

    // last dot of every line hands the loaded sprites to the slots
    assign commit = end_of_line;

    // dot 1 of the pre-render line
    assign frame_clear = (row == sprite_pkg::dot_t'(`PRERENDER_LINE)) && (col == 9'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vblank <= 1'b0;
        end else if (row == sprite_pkg::dot_t'(`VBLANK_LINE) && col == 9'd1) begin
            vblank <= 1'b1;
        end else if (frame_clear) begin
            vblank <= 1'b0;
        end
    end

    // active low, held for the whole blank while enabled
    assign nmi_n = !(vblank && nmi_enable);

    col_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        col <= sprite_pkg::dot_t'(`DOTS_PER_LINE - 1)
    ) else $error("col ran past the last dot of the line");

endmodule

`default_nettype wire

//--- sprite_loader.sv
`timescale 1ns/100ps
`default_nettype none
`include "ppu_settings.svh"

module sprite_loader (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 load,
    input  wire sprite_pkg::pattern_t load_x,
    input  wire sprite_pkg::attr_t    load_attr,
    input  wire sprite_pkg::pattern_t load_pat_lo,
    input  wire sprite_pkg::pattern_t load_pat_hi,
    input  wire logic                 commit,
    input  wire logic                 frame_clear,
    output logic                      slot_wr,
    output sprite_pkg::pattern_t      slot_x      [`SPRITE_SLOTS],
    output sprite_pkg::attr_t         slot_attr   [`SPRITE_SLOTS],
    output sprite_pkg::pattern_t      slot_pat_lo [`SPRITE_SLOTS],
    output sprite_pkg::pattern_t      slot_pat_hi [`SPRITE_SLOTS],
    output logic                      sprite_overflow
);

    sprite_pkg::pattern_t    x_q      [`SPRITE_SLOTS];
    sprite_pkg::attr_t       attr_q   [`SPRITE_SLOTS];
    sprite_pkg::pattern_t    pat_lo_q [`SPRITE_SLOTS];
    sprite_pkg::pattern_t    pat_hi_q [`SPRITE_SLOTS];
    sprite_pkg::slot_count_t count;
    logic                    full;

    assign full = (count == sprite_pkg::slot_count_t'(`SPRITE_SLOTS));

    // pending entries, written in arrival order
    always_ff @(posedge clk) begin
        if (load && !full) begin
            x_q[count[2:0]]      <= load_x;
            attr_q[count[2:0]]   <= load_attr;
            pat_lo_q[count[2:0]] <= load_pat_lo;
            pat_hi_q[count[2:0]] <= load_pat_hi;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count           <= '0;
            sprite_overflow <= 1'b0;
        end else begin
            if (commit) begin
                count <= '0;
            end else if (load && !full) begin
                count <= count + 1'b1;
            end
            if (frame_clear) begin
                sprite_overflow <= 1'b0;
            end
            // a ninth sprite on the same line
            if (load && full) begin
                sprite_overflow <= 1'b1;
            end
        end
    end

    assign slot_wr = commit;

    // entries beyond count go out with blank patterns
    always_comb begin
        for (int i = 0; i < `SPRITE_SLOTS; i++) begin
            slot_x[i]      = x_q[i];
            slot_attr[i]   = attr_q[i];
            slot_pat_lo[i] = (sprite_pkg::slot_count_t'(i) < count) ? pat_lo_q[i] : '0;
            slot_pat_hi[i] = (sprite_pkg::slot_count_t'(i) < count) ? pat_hi_q[i] : '0;
        end
    end

    no_load_on_commit: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load && commit)
    ) else $error("sprite load collided with end-of-line commit");

endmodule

`default_nettype wire

//--- sprite_slot.sv
`timescale 1ns/100ps
`default_nettype none
`include "ppu_settings.svh"

module sprite_slot (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 wr,
    input  wire sprite_pkg::pattern_t wr_x,
    input  wire sprite_pkg::attr_t    wr_attr,
    input  wire sprite_pkg::pattern_t wr_pat_lo,
    input  wire sprite_pkg::pattern_t wr_pat_hi,
    input  wire sprite_pkg::dot_t     col,
    output sprite_pkg::color_index_t  color_index,
    output logic                      behind_bg
);

    sprite_pkg::pattern_t x_q;
    sprite_pkg::attr_t    attr_q;
    sprite_pkg::pattern_t pat_lo_q;
    sprite_pkg::pattern_t pat_hi_q;
    sprite_pkg::dot_t     offset;
    logic                 in_range;
    logic [2:0]           bit_sel;
    logic [1:0]           pixel;

    always_ff @(posedge clk) begin
        if (wr) begin
            x_q    <= wr_x;
            attr_q <= wr_attr;
        end
    end

    // blank patterns keep the slot transparent out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pat_lo_q <= '0;
            pat_hi_q <= '0;
        end else if (wr) begin
            pat_lo_q <= wr_pat_lo;
            pat_hi_q <= wr_pat_hi;
        end
    end

    assign offset   = col - {1'b0, x_q};
    assign in_range = (col >= {1'b0, x_q}) && (offset < 9'd8);

    // msb is the leftmost dot unless flipped
    assign bit_sel = attr_q[`ATTR_HFLIP_BIT] ? offset[2:0] : 3'd7 - offset[2:0];
    assign pixel   = in_range ? {pat_hi_q[bit_sel], pat_lo_q[bit_sel]} : 2'b00;

    assign color_index = {attr_q[`ATTR_PAL_MSB:`ATTR_PAL_LSB], pixel};
    assign behind_bg   = attr_q[`ATTR_PRIO_BIT];

endmodule

`default_nettype wire

//--- pixel_merge.sv
`timescale 1ns/100ps
`default_nettype none
`include "ppu_settings.svh"

module pixel_merge (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire sprite_pkg::dot_t         col,
    input  wire logic                     visible,
    input  wire logic                     frame_clear,
    input  wire sprite_pkg::color_index_t slot_index  [`SPRITE_SLOTS],
    input  wire logic                     slot_behind [`SPRITE_SLOTS],
    input  wire sprite_pkg::color_index_t bg_index,
    input  wire logic                     show_bg,
    input  wire logic                     show_sp,
    input  wire logic                     show_bg_left,
    input  wire logic                     show_sp_left,
    output logic                          pixel_valid,
    output sprite_pkg::pal_addr_t         pixel_addr,
    output logic                          sprite_zero_hit
);

    logic                     left_edge;
    logic                     sp_on;
    sprite_pkg::color_index_t bg_masked;
    sprite_pkg::color_index_t sp_index;
    logic                     sp_behind;
    logic                     bg_opaque;
    logic                     sp_opaque;
    logic                     zero_hit;
    sprite_pkg::pal_addr_t    merged;

    assign left_edge = (col < sprite_pkg::dot_t'(`LEFT_CLIP_DOTS));
    assign bg_masked = (!show_bg || (left_edge && !show_bg_left)) ? '0 : bg_index;
    assign sp_on     = show_sp && !(left_edge && !show_sp_left);

    // walk down so the lowest opaque slot is the one left standing
    always_comb begin
        sp_index  = '0;
        sp_behind = 1'b0;
        for (int i = `SPRITE_SLOTS - 1; i >= 0; i--) begin
            if (slot_index[i][1:0] != 2'b00) begin
                sp_index  = slot_index[i];
                sp_behind = slot_behind[i];
            end
        end
        if (!sp_on) begin
            sp_index = '0;
        end
    end

    assign bg_opaque = (bg_masked[1:0] != 2'b00);
    assign sp_opaque = (sp_index[1:0] != 2'b00);

    // sprite wins unless transparent or behind opaque background
    assign merged = (sp_opaque && !(bg_opaque && sp_behind)) ? {1'b1, sp_index}
                                                             : {1'b0, bg_masked};

    // slot 0 against background, right-most dot excluded
    assign zero_hit = visible && (col < sprite_pkg::dot_t'(`SCREEN_WIDTH - 1)) &&
                      sp_on && (slot_index[0][1:0] != 2'b00) && bg_opaque;

    always_ff @(posedge clk) begin
        pixel_addr <= merged;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_valid     <= 1'b0;
            sprite_zero_hit <= 1'b0;
        end else begin
            pixel_valid <= visible;
            if (frame_clear) begin
                sprite_zero_hit <= 1'b0;
            end else if (zero_hit) begin
                sprite_zero_hit <= 1'b1;
            end
        end
    end

    valid_follows_visible: assert property (
        @(posedge clk) disable iff (!rst_n)
        pixel_valid |-> $past(visible)
    ) else $error("pixel_valid without a visible dot one clock earlier");

endmodule

`default_nettype wire

//--- sprite_render.sv
`timescale 1ns/100ps
`default_nettype none
`include "ppu_settings.svh"

module sprite_render (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     load,
    input  wire sprite_pkg::pattern_t     load_x,
    input  wire sprite_pkg::attr_t        load_attr,
    input  wire sprite_pkg::pattern_t     load_pat_lo,
    input  wire sprite_pkg::pattern_t     load_pat_hi,
    input  wire sprite_pkg::color_index_t bg_index,
    input  wire logic                     show_bg,
    input  wire logic                     show_sp,
    input  wire logic                     show_bg_left,
    input  wire logic                     show_sp_left,
    input  wire logic                     nmi_enable,
    output sprite_pkg::dot_t              col,
    output sprite_pkg::dot_t              row,
    output logic                          pixel_valid,
    output sprite_pkg::pal_addr_t         pixel_addr,
    output logic                          vblank,
    output logic                          nmi_n,
    output logic                          sprite_overflow,
    output logic                          sprite_zero_hit
);

    logic                     visible;
    logic                     commit;
    logic                     frame_clear;
    logic                     slot_wr;
    sprite_pkg::pattern_t     slot_x      [`SPRITE_SLOTS];
    sprite_pkg::attr_t        slot_attr   [`SPRITE_SLOTS];
    sprite_pkg::pattern_t     slot_pat_lo [`SPRITE_SLOTS];
    sprite_pkg::pattern_t     slot_pat_hi [`SPRITE_SLOTS];
    sprite_pkg::color_index_t slot_index  [`SPRITE_SLOTS];
    logic                     slot_behind [`SPRITE_SLOTS];

    dot_timing i_dot_timing (
        .clk, .rst_n, .nmi_enable,
        .col, .row, .visible, .commit, .frame_clear, .vblank, .nmi_n
    );

    sprite_loader i_sprite_loader (
        .clk, .rst_n,
        .load, .load_x, .load_attr, .load_pat_lo, .load_pat_hi,
        .commit, .frame_clear,
        .slot_wr, .slot_x, .slot_attr, .slot_pat_lo, .slot_pat_hi,
        .sprite_overflow
    );

    // one slot per sprite on the line, slot 0 is sprite zero
    for (genvar i = 0; i < `SPRITE_SLOTS; i++) begin : g_slot
        sprite_slot i_sprite_slot (
            .clk, .rst_n,
            .wr          (slot_wr),
            .wr_x        (slot_x[i]),
            .wr_attr     (slot_attr[i]),
            .wr_pat_lo   (slot_pat_lo[i]),
            .wr_pat_hi   (slot_pat_hi[i]),
            .col,
            .color_index (slot_index[i]),
            .behind_bg   (slot_behind[i])
        );
    end

    pixel_merge i_pixel_merge (
        .clk, .rst_n, .col, .visible, .frame_clear,
        .slot_index, .slot_behind, .bg_index,
        .show_bg, .show_sp, .show_bg_left, .show_sp_left,
        .pixel_valid, .pixel_addr, .sprite_zero_hit
    );

endmodule

`default_nettype wire

//--- tb_sprite_render.sv
`timescale 1ns/100ps
`default_nettype none
`include "ppu_settings.svh"

module tb_sprite_render;

    localparam int CLK_HALF    = 20;
    localparam int DRIVE_DELAY = 2;
    // tests end near line 785, about three frames of 341 x 262 dots
    localparam int TIMEOUT_CYCLES = 300000;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     load;
    sprite_pkg::pattern_t     load_x;
    sprite_pkg::attr_t        load_attr;
    sprite_pkg::pattern_t     load_pat_lo;
    sprite_pkg::pattern_t     load_pat_hi;
    sprite_pkg::color_index_t bg_index;
    logic                     show_bg;
    logic                     show_sp;
    logic                     show_bg_left;
    logic                     show_sp_left;
    logic                     nmi_enable;
    sprite_pkg::dot_t         col;
    sprite_pkg::dot_t         row;
    logic                     pixel_valid;
    sprite_pkg::pal_addr_t    pixel_addr;
    logic                     vblank;
    logic                     nmi_n;
    logic                     sprite_overflow;
    logic                     sprite_zero_hit;

    // entries loaded on one line and expected on the next
    logic [7:0] spr_x    [0:8];
    logic [7:0] spr_attr [0:8];
    logic [7:0] spr_lo   [0:8];
    logic [7:0] spr_hi   [0:8];
    int         spr_drawn;
    int         bg_mode;
    logic [3:0] bg_fill;
    integer     seed;
    int         cycle_count = 0;
    int         errors = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;

    sprite_render i_sprite_render (
        .clk, .rst_n, .load, .load_x, .load_attr, .load_pat_lo, .load_pat_hi,
        .bg_index, .show_bg, .show_sp, .show_bg_left, .show_sp_left, .nmi_enable,
        .col, .row, .pixel_valid, .pixel_addr, .vblank, .nmi_n,
        .sprite_overflow, .sprite_zero_hit
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic wait_dot(input int r, input int c);
        while (!(row == r && col == c)) begin
            next_cycle();
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // 2-bit pattern value of one expected sprite at a column
    function automatic logic [1:0] sprite_pixel(input int idx, input int c);
        int offset;
        int b;
        offset = c - int'(spr_x[idx]);
        if (offset < 0 || offset > 7) begin
            return 2'b00;
        end
        b = spr_attr[idx][`ATTR_HFLIP_BIT] ? offset : 7 - offset;
        return {spr_hi[idx][b], spr_lo[idx][b]};
    endfunction

    function automatic logic [4:0] expected_addr(input int c, input logic [3:0] bg);
        logic [3:0] bg_vis;
        logic       sp_on;
        logic       found;
        logic [3:0] sp;
        logic       behind;
        logic [1:0] value;
        bg_vis = bg;
        if (!show_bg || (c < `LEFT_CLIP_DOTS && !show_bg_left)) begin
            bg_vis = 4'h0;
        end
        sp_on  = show_sp && !(c < `LEFT_CLIP_DOTS && !show_sp_left);
        found  = 1'b0;
        sp     = 4'h0;
        behind = 1'b0;
        for (int i = 0; i < spr_drawn; i++) begin
            value = sprite_pixel(i, c);
            if (sp_on && !found && value != 2'b00) begin
                found  = 1'b1;
                sp     = {spr_attr[i][1:0], value};
                behind = spr_attr[i][`ATTR_PRIO_BIT];
            end
        end
        if (found && !(behind && bg_vis[1:0] != 2'b00)) begin
            return {1'b1, sp};
        end
        return {1'b0, bg_vis};
    endfunction

    function automatic logic [3:0] bg_for_col(input int c);
        case (bg_mode)
            1: return bg_fill;
            // opaque and transparent in runs of eight dots
            2: return c[3] ? bg_fill : {bg_fill[3:2], 2'b00};
            default: return 4'h0;
        endcase
    endfunction

    task automatic make_random_sprite(input int i);
        spr_x[i]    = $random(seed);
        spr_attr[i] = $random(seed) & 8'h43;
        spr_lo[i]   = $random(seed);
        spr_hi[i]   = $random(seed);
    endtask

    // strobes count entries at col 260 of a line, well clear of the commit
    task automatic load_sprites(input int line, input int count);
        wait_dot(line, 260);
        for (int i = 0; i < count; i++) begin
            load        = 1'b1;
            load_x      = spr_x[i];
            load_attr   = spr_attr[i];
            load_pat_lo = spr_lo[i];
            load_pat_hi = spr_hi[i];
            next_cycle();
        end
        load = 1'b0;
    endtask

    task automatic check_scanline(input string name, input int line);
        logic [3:0] bg;
        logic [4:0] expected;
        wait_dot(line, 0);
        for (int c = 0; c < `SCREEN_WIDTH; c++) begin
            bg       = bg_for_col(c);
            bg_index = bg;
            expected = expected_addr(c, bg);
            next_cycle();
            check_value($sformatf("%s valid col %0d", name, c), 1, pixel_valid);
            check_value($sformatf("%s addr col %0d", name, c), expected, pixel_addr);
        end
        // first dot past the visible width
        next_cycle();
        check_value($sformatf("%s valid end", name), 0, pixel_valid);
    endtask

    task automatic frame_timing();
        int errors_before;
        errors_before = errors;
        nmi_enable = 1'b1;
        while (vblank !== 1'b1) begin
            next_cycle();
        end
        check_value("frame_timing vblank row", `VBLANK_LINE, row);
        check_value("frame_timing vblank col", 2, col);
        check_value("frame_timing nmi_n", 0, nmi_n);
        nmi_enable = 1'b0;
        next_cycle();
        check_value("frame_timing nmi_n masked", 1, nmi_n);
        nmi_enable = 1'b1;
        while (vblank !== 1'b0) begin
            next_cycle();
        end
        check_value("frame_timing clear row", `PRERENDER_LINE, row);
        check_value("frame_timing clear col", 2, col);
        check_value("frame_timing nmi_n idle", 1, nmi_n);
        report_test("frame_timing", errors_before);
    endtask

    task automatic single_sprite();
        int errors_before;
        errors_before = errors;
        bg_mode = 0;
        make_random_sprite(0);
        spr_drawn = 1;
        load_sprites(9, 1);
        check_scanline("single_sprite", 10);
        report_test("single_sprite", errors_before);
    endtask

    task automatic priority_and_flip();
        int errors_before;
        errors_before = errors;
        // flipped sprite in slot 0, second sprite overlaps its right half
        spr_x[0]    = 8'd16 + ($random(seed) & 8'h7f);
        spr_attr[0] = 8'h41;
        spr_lo[0]   = $random(seed);
        spr_hi[0]   = 8'hff;
        spr_x[1]    = spr_x[0] + 8'd4;
        spr_attr[1] = 8'h02;
        spr_lo[1]   = 8'hff;
        spr_hi[1]   = $random(seed);
        spr_drawn   = 2;
        bg_mode     = 1;
        bg_fill     = 4'b1101;
        load_sprites(19, 2);
        check_scanline("priority_front", 20);
        spr_attr[0] = spr_attr[0] | 8'h20;
        spr_attr[1] = spr_attr[1] | 8'h20;
        bg_mode     = 2;
        load_sprites(21, 2);
        check_scanline("priority_behind", 22);
        bg_mode  = 0;
        bg_index = 4'h0;
        report_test("priority_and_flip", errors_before);
    endtask

    task automatic overflow();
        int errors_before;
        errors_before = errors;
        for (int i = 0; i < 8; i++) begin
            make_random_sprite(i);
            spr_x[i] = spr_x[i] & 8'h7f;
        end
        // ninth sprite sits alone so a stray draw would show
        spr_x[8]    = 8'd200;
        spr_attr[8] = 8'h03;
        spr_lo[8]   = 8'hff;
        spr_hi[8]   = 8'hff;
        spr_drawn   = 8;
        load_sprites(29, 9);
        check_value("overflow set", 1, sprite_overflow);
        check_scanline("overflow draw", 30);
        wait_dot(`PRERENDER_LINE, 1);
        check_value("overflow held", 1, sprite_overflow);
        next_cycle();
        check_value("overflow cleared", 0, sprite_overflow);
        report_test("overflow", errors_before);
    endtask

    task automatic zero_hit_and_clip();
        int errors_before;
        errors_before = errors;
        spr_x[0]     = 8'd0;
        spr_attr[0]  = 8'h00;
        spr_lo[0]    = 8'hff;
        spr_hi[0]    = $random(seed);
        spr_drawn    = 1;
        bg_mode      = 1;
        bg_fill      = 4'b0110;
        show_sp_left = 1'b0;
        load_sprites(9, 1);
        check_scanline("clip_left", 10);
        check_value("zero_hit clipped", 0, sprite_zero_hit);
        show_sp_left = 1'b1;
        load_sprites(11, 1);
        check_value("zero_hit before line", 0, sprite_zero_hit);
        check_scanline("zero_hit draw", 12);
        check_value("zero_hit set", 1, sprite_zero_hit);
        wait_dot(`PRERENDER_LINE, 1);
        check_value("zero_hit held", 1, sprite_zero_hit);
        next_cycle();
        check_value("zero_hit cleared", 0, sprite_zero_hit);
        report_test("zero_hit_and_clip", errors_before);
    endtask

    initial begin
        seed         = 32'h878c_9f27;
        rst_n        = 1'b0;
        load         = 1'b0;
        load_x       = '0;
        load_attr    = '0;
        load_pat_lo  = '0;
        load_pat_hi  = '0;
        bg_index     = '0;
        show_bg      = 1'b1;
        show_sp      = 1'b1;
        show_bg_left = 1'b1;
        show_sp_left = 1'b1;
        nmi_enable   = 1'b0;
        spr_drawn    = 0;
        bg_mode      = 0;
        bg_fill      = 4'h0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        frame_timing();
        single_sprite();
        priority_and_flip();
        overflow();
        zero_hit_and_clip();

        $display("summary: %0d tests passed, %0d tests failed, %0d checks failed",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sprite_render.f
+incdir+.
sprite_pkg.sv
dot_timing.sv
sprite_loader.sv
sprite_slot.sv
pixel_merge.sv
sprite_render.sv
tb_sprite_render.sv

//--- Bender.yml
package:
  name: sprite_render

sources:
  - include_dirs:
      - .
    files:
      - sprite_pkg.sv
      - dot_timing.sv
      - sprite_loader.sv
      - sprite_slot.sv
      - pixel_merge.sv
      - sprite_render.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_sprite_render.sv
